// ==== run_sim.sh ====
#!/bin/bash
# build and run the SD host testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_sd_host -o tb_sd_host
./obj_dir/tb_sd_host | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	exit 1
fi
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

// ==== sd_card_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// card controller FSM: power-up, identification,
// selection, bus width and single block reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_card_ctrl (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     rise_tick,
	input  logic                     rd_req,
	input  logic [31:0]              rd_block,
	input  logic                     cmd_sent,
	input  logic                     resp_done,
	input  logic                     resp_timeout,
	input  sd_proto_pkg::resp_t      resp_data,
	input  logic                     data_done,
	input  logic                     data_timeout,
	output logic                     fast_mode,
	output logic                     cmd_start,
	output sd_proto_pkg::cmd_frame_t cmd_frame,
	output logic                     resp_start,
	output logic                     resp_long,
	output logic                     data_start,
	output logic                     card_ready,
	output logic                     init_error,
	output logic                     rd_busy,
	output logic                     rd_done,
	output logic                     rd_error
);
	import sd_proto_pkg::*;
	import sd_timing_pkg::*;

	localparam int WW = $clog2(POWERUP_TICKS);

	typedef enum logic [3:0] {
		S_POWERUP, S_CMD0, S_GAP, S_CMD8, S_CMD55, S_ACMD41, S_CMD2,
		S_CMD3, S_CMD7, S_ACMD6, S_READY, S_READ, S_ERROR
	} ctrl_state_e;

	ctrl_state_e   state;
	card_type_e    card_type;
	logic [15:0]   rca;
	logic [31:0]   blk_addr;
	logic [WW-1:0] wait_cnt;
	logic          issued;   // command of this state is out
	logic          is_cmd;
	logic          got_resp;

	assign is_cmd     = !(state inside {S_POWERUP, S_GAP, S_READY, S_ERROR});
	assign got_resp   = issued & resp_done;
	assign card_ready = (state == S_READY) || (state == S_READ);
	assign rd_busy    = (state == S_READ);
	assign init_error = (state == S_ERROR);
	assign resp_long  = (state == S_CMD2); // r2 carries the cid

	always_comb
	begin
		case (state)
			S_CMD8:   cmd_frame = {CMD_SEND_IF_COND, IF_COND_ARG};
			S_CMD55:  cmd_frame = {CMD_APP, rca, 16'h0000}; // rca still 0 during init
			S_ACMD41: cmd_frame = {ACMD_SEND_OP_COND,
				(card_type == CARD_V1_SDSC) ? OCR_STD_ARG : OCR_HCS_ARG};
			S_CMD2:   cmd_frame = {CMD_ALL_SEND_CID, 32'h0};
			S_CMD3:   cmd_frame = {CMD_SEND_RCA, 32'h0};
			S_CMD7:   cmd_frame = {CMD_SELECT, rca, 16'h0000};
			S_ACMD6:  cmd_frame = {ACMD_BUS_WIDTH, BUS_WIDTH_4_ARG};
			S_READ:   cmd_frame = {CMD_READ_SINGLE, blk_addr};
			default:  cmd_frame = {CMD_GO_IDLE, 32'h0};
		endcase
	end

	// sdsc cards take a byte address
	always_ff @(posedge sys_clk)
	begin
		if (state == S_READY && rd_req)
			blk_addr <= (card_type == CARD_SDHC) ? rd_block : {rd_block[22:0], 9'b0};
	end

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= S_POWERUP;
			card_type  <= CARD_NONE;
			rca        <= '0;
			wait_cnt   <= '0;
			issued     <= 1'b0;
			fast_mode  <= 1'b0;
			cmd_start  <= 1'b0;
			resp_start <= 1'b0;
			data_start <= 1'b0;
			rd_done    <= 1'b0;
			rd_error   <= 1'b0;
		end
		else
		begin
			cmd_start  <= 1'b0;
			resp_start <= 1'b0;
			data_start <= 1'b0;
			rd_done    <= 1'b0;
			rd_error   <= 1'b0;
			if (is_cmd && !issued)
			begin
				cmd_start  <= 1'b1;
				resp_start <= (state != S_CMD0); // cmd0 has no response
				data_start <= (state == S_READ);
				issued     <= 1'b1;
			end
			case (state)
				S_POWERUP:
					if (rise_tick)
					begin
						if (wait_cnt == WW'(POWERUP_TICKS - 1))
							state <= S_CMD0;
						wait_cnt <= wait_cnt + 1'b1;
					end
				S_CMD0:
					if (issued && cmd_sent)
					begin
						issued   <= 1'b0;
						wait_cnt <= '0;
						state    <= S_GAP;
					end
				S_GAP:
					if (rise_tick)
					begin
						wait_cnt <= wait_cnt + 1'b1;
						if (wait_cnt == WW'(NCC_TICKS - 1))
							state <= (card_type == CARD_V1_SDSC) ? S_CMD55 : S_CMD8;
					end
				S_CMD8:
					if (got_resp)
					begin
						issued <= 1'b0;
						if (resp_timeout)
						begin
							card_type <= CARD_V1_SDSC; // silent card, second cmd0
							state     <= S_CMD0;
						end
						else if (resp_data[RESP_IDX_LSB +: 6] == CMD_SEND_IF_COND &&
							resp_data[RESP_ARG_LSB +: 12] == IF_COND_ARG[11:0])
						begin
							card_type <= CARD_V2_SDSC;
							state     <= S_CMD55;
						end
						else
							state <= S_ERROR;
					end
				S_CMD55:
					if (got_resp)
					begin
						issued <= 1'b0;
						if (resp_timeout || !resp_data[APP_CMD_BIT])
							state <= S_ERROR;
						else
							state <= fast_mode ? S_ACMD6 : S_ACMD41;
					end
				S_ACMD41:
					if (got_resp)
					begin
						issued <= 1'b0;
						if (resp_timeout)
							state <= S_ERROR;
						else if (!resp_data[OCR_BUSY_BIT])
							state <= S_CMD55; // card still busy
						else
						begin
							if (resp_data[OCR_CCS_BIT] && card_type == CARD_V2_SDSC)
								card_type <= CARD_SDHC;
							state <= S_CMD2;
						end
					end
				S_CMD2:
					if (got_resp)
					begin
						issued <= 1'b0;
						state  <= resp_timeout ? S_ERROR : S_CMD3;
					end
				S_CMD3:
					if (got_resp)
					begin
						issued <= 1'b0;
						if (resp_timeout)
							state <= S_ERROR;
						else
						begin
							rca       <= resp_data[RESP_ARG_LSB + 16 +: 16];
							fast_mode <= 1'b1;
							state     <= S_CMD7;
						end
					end
				S_CMD7:
					if (got_resp)
					begin
						issued <= 1'b0;
						state  <= resp_timeout ? S_ERROR : S_CMD55;
					end
				S_ACMD6:
					if (got_resp)
					begin
						issued <= 1'b0;
						state  <= resp_timeout ? S_ERROR : S_READY;
					end
				S_READY:
					if (rd_req)
						state <= S_READ;
				S_READ:
					if (issued && data_done) // r1 ends well before the block
					begin
						issued   <= 1'b0;
						rd_done  <= 1'b1;
						rd_error <= data_timeout;
						state    <= S_READY;
					end
				default:
					state <= S_ERROR;
			endcase
		end
	end

endmodule

// ==== sd_card_model.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioural SD card: command decode with crc7
// check, R1/R2/R3/R6/R7 responses, 4-bit block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_card_model #(
	parameter logic [15:0] CARD_RCA = 16'hb37a
) (
	input  logic        sd_clk,
	input  logic        cmd_oe,
	input  logic        cmd_out,
	input  logic        sdhc_mode,  // 0 gives a v1 card, silent on cmd8
	input  logic        withhold,
	input  logic [7:0]  blk_mem [0:511],
	output logic        cmd_in,
	output logic [3:0]  dat_in,
	output int          cmd_cnt,
	output logic [5:0]  last_idx,
	output logic [31:0] last_arg,
	output logic        frame_ok
);
	logic [47:0] frame;
	logic [31:0] ocr;
	int          busy_left;

	function automatic logic [6:0] calc_crc7(input logic [39:0] bits);
		logic [6:0] crc;
		logic       fb;
		crc = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb  = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00); // x^7 + x^3 + 1
		end
		return crc;
	endfunction

	function automatic logic [47:0] make_short(input logic [5:0] idx, input logic [31:0] arg);
		logic [39:0] body;
		body = {2'b00, idx, arg};
		return {body, calc_crc7(body), 1'b1};
	endfunction

	task automatic take_command(output logic [47:0] f);
		f = '0;
		@(posedge sd_clk);
		while (!(cmd_oe && !cmd_out)) // start bit from the host
			@(posedge sd_clk);
		for (int i = 46; i >= 0; i--)
		begin
			@(posedge sd_clk);
			f[i] = cmd_out;
		end
	endtask

	task automatic send_resp(input logic [135:0] r, input int n);
		repeat (2) @(negedge sd_clk); // ncr
		for (int i = n - 1; i >= 0; i--)
		begin
			cmd_in = r[i];
			@(negedge sd_clk);
		end
		cmd_in = 1'b1;
	endtask

	task automatic send_block();
		@(negedge sd_clk);
		dat_in = 4'h0; // start nibble
		for (int b = 0; b < 512; b++)
		begin
			@(negedge sd_clk);
			dat_in = blk_mem[b][7:4];
			@(negedge sd_clk);
			dat_in = blk_mem[b][3:0];
		end
		repeat (16)
		begin
			@(negedge sd_clk);
			dat_in = 4'h0; // crc16 not modelled
		end
		@(negedge sd_clk);
		dat_in = 4'hf;
		@(negedge sd_clk);
	endtask

	initial
	begin
		cmd_in    = 1'b1;
		dat_in    = 4'hf;
		cmd_cnt   = 0;
		last_idx  = '0;
		last_arg  = '0;
		frame_ok  = 1'b0;
		busy_left = 2;
		forever
		begin
			take_command(frame);
			last_idx = frame[45:40];
			last_arg = frame[39:8];
			frame_ok = frame[46] && frame[0] && (calc_crc7(frame[47:8]) == frame[7:1]);
			cmd_cnt++;
			case (frame[45:40])
				6'd0:
					busy_left = 2;
				6'd8:
					if (sdhc_mode)
						send_resp(136'(make_short(6'd8, {20'h0, frame[19:8]})), 48);
				6'd55:
					send_resp(136'(make_short(6'd55, 32'h0000_0120)), 48); // app_cmd set
				6'd41:
				begin
					ocr = {(busy_left == 0), sdhc_mode, 6'h00, 24'hff8000};
					if (busy_left > 0)
						busy_left--;
					send_resp(136'({2'b00, 6'h3f, ocr, 7'h7f, 1'b1}), 48);
				end
				6'd2:
					send_resp({2'b00, 6'h3f, 127'h1234_5678_9abc_def0_1234_5678_9abc_def0,
						1'b1}, 136);
				6'd3:
					send_resp(136'(make_short(6'd3, {CARD_RCA, 16'h0500})), 48);
				6'd17:
				begin
					send_resp(136'(make_short(6'd17, 32'h0000_0900)), 48);
					if (!withhold)
						send_block();
				end
				default:
					send_resp(136'(make_short(frame[45:40], 32'h0000_0900)), 48);
			endcase
		end
	end

endmodule

// ==== sd_clk_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sd_clk divider with init and transfer rates,
// rise and fall tick strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_clk_gen (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic fast_mode,
	output logic sd_clk,
	output logic rise_tick,
	output logic fall_tick
);
	import sd_timing_pkg::*;

	localparam int CW = $clog2(INIT_HALF);

	logic [CW-1:0] half_cnt;
	logic [CW-1:0] half_max;
	logic          half_end;

	assign half_max = fast_mode ? CW'(DATA_HALF - 1) : CW'(INIT_HALF - 1);
	assign half_end = (half_cnt >= half_max); // catches a rate switch mid-count

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			half_cnt  <= '0;
			sd_clk    <= 1'b0;
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
		end
		else
		begin
			rise_tick <= half_end & ~sd_clk; // high in the cycle sd_clk goes high
			fall_tick <= half_end & sd_clk;
			if (half_end)
			begin
				half_cnt <= '0;
				sd_clk   <= ~sd_clk;
			end
			else
				half_cnt <= half_cnt + 1'b1;
		end
	end

endmodule

// ==== sd_cmd_tx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command line serializer: 48-bit frame with
// bit-serial crc7 and end bit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_cmd_tx (
	input  logic                     sys_clk,
	input  logic                     rst_n,
	input  logic                     fall_tick,
	input  logic                     cmd_start,
	input  sd_proto_pkg::cmd_frame_t cmd_frame,
	output logic                     cmd_oe,
	output logic                     cmd_out,
	output logic                     cmd_sent
);
	import sd_timing_pkg::*;

	localparam int BODY_BITS = SHORT_BITS - 8; // start, transmit, index, argument

	logic [BODY_BITS-1:0] shift_q;
	logic [6:0]           crc_q;
	logic [5:0]           bit_cnt;
	logic                 busy;
	logic                 crc_fb;

	assign crc_fb = shift_q[BODY_BITS-1] ^ crc_q[6]; // x^7 + x^3 + 1

	always_ff @(posedge sys_clk)
	begin
		if (cmd_start && !busy)
			shift_q <= {2'b01, cmd_frame};
		else if (busy && fall_tick && bit_cnt < 6'(BODY_BITS))
			shift_q <= shift_q << 1;
	end

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			crc_q    <= '0;
			cmd_oe   <= 1'b0;
			cmd_out  <= 1'b1;
			cmd_sent <= 1'b0;
		end
		else
		begin
			cmd_sent <= 1'b0;
			if (cmd_start && !busy)
			begin
				busy    <= 1'b1;
				bit_cnt <= '0;
				crc_q   <= '0;
			end
			else if (busy && fall_tick)
			begin
				if (bit_cnt == 6'(SHORT_BITS))
				begin
					// this fall ends the end bit, line goes back to the card
					busy     <= 1'b0;
					cmd_oe   <= 1'b0;
					cmd_out  <= 1'b1;
					cmd_sent <= 1'b1;
				end
				else
				begin
					cmd_oe  <= 1'b1;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt < 6'(BODY_BITS))
					begin
						cmd_out <= shift_q[BODY_BITS-1];
						crc_q   <= {crc_q[5:0], crc_fb} ^ {3'b000, crc_fb, 3'b000};
					end
					else if (bit_cnt < 6'(SHORT_BITS - 1))
					begin
						cmd_out <= crc_q[6]; // crc msb first
						crc_q   <= {crc_q[5:0], 1'b0};
					end
					else
						cmd_out <= 1'b1; // end bit
				end
			end
		end
	end

endmodule

// ==== sd_data_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4-bit block receiver: start nibble hunt with
// timeout, nibble pairing, tail skip
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_data_rx (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       rise_tick,
	input  logic       data_start,
	input  logic       cmd_sent,
	input  logic [3:0] dat_in,
	output logic       rd_valid,
	output logic [7:0] rd_data,
	output logic       data_done,
	output logic       data_timeout
);
	import sd_timing_pkg::*;

	localparam int TW = $clog2(DATA_TIMEOUT);
	localparam int CW = $clog2(BLOCK_BYTES);

	typedef enum logic [2:0] {D_IDLE, D_WAIT, D_HUNT, D_DATA, D_TAIL} dx_state_e;

	dx_state_e     state;
	logic [TW-1:0] tick_cnt;
	logic [CW-1:0] byte_cnt;
	logic          low_half; // next nibble completes a byte
	logic [3:0]    hi_nib;

	always_ff @(posedge sys_clk)
	begin
		if (state == D_DATA && rise_tick)
		begin
			if (!low_half)
				hi_nib <= dat_in;
			else
				rd_data <= {hi_nib, dat_in}; // high nibble first
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= D_IDLE;
			tick_cnt     <= '0;
			byte_cnt     <= '0;
			low_half     <= 1'b0;
			rd_valid     <= 1'b0;
			data_done    <= 1'b0;
			data_timeout <= 1'b0;
		end
		else
		begin
			rd_valid     <= 1'b0;
			data_done    <= 1'b0;
			data_timeout <= 1'b0;
			case (state)
				D_IDLE:
					if (data_start)
						state <= D_WAIT;
				D_WAIT:
					if (cmd_sent)
					begin
						tick_cnt <= '0;
						state    <= D_HUNT;
					end
				D_HUNT:
					if (rise_tick)
					begin
						if (dat_in == 4'h0)
						begin
							byte_cnt <= '0;
							low_half <= 1'b0;
							state    <= D_DATA;
						end
						else if (tick_cnt == TW'(DATA_TIMEOUT - 1))
						begin
							data_done    <= 1'b1;
							data_timeout <= 1'b1;
							state        <= D_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				D_DATA:
					if (rise_tick)
					begin
						low_half <= ~low_half;
						if (low_half)
						begin
							rd_valid <= 1'b1;
							byte_cnt <= byte_cnt + 1'b1;
							if (byte_cnt == CW'(BLOCK_BYTES - 1))
							begin
								tick_cnt <= '0;
								state    <= D_TAIL;
							end
						end
					end
				D_TAIL:
					if (rise_tick) // crc16 and end nibble, not checked
					begin
						if (tick_cnt == TW'(DATA_TAIL_TICKS - 1))
						begin
							data_done <= 1'b1;
							state     <= D_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				default:
					state <= D_IDLE;
			endcase
		end
	end

endmodule

// ==== sd_host_sva.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions bound to the SD host top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_host_sva (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       cmd_oe,
	input  logic       rd_valid,
	input  logic       rd_busy,
	input  logic       rd_done,
	input  logic [2:0] rx_state
);
	logic rx_armed;

	assign rx_armed = (rx_state == 3'd2) || (rx_state == 3'd3); // hunt or shift

	a_cmd_quiet: assert property (@(posedge sys_clk) disable iff (!rst_n)
		rx_armed |-> !cmd_oe)
		else $error("cmd_oe high while the response receiver is armed");

	a_valid_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
		rd_valid |-> rd_busy)
		else $error("rd_valid outside a read");

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
		rd_done |=> !rd_done)
		else $error("rd_done longer than one cycle");

endmodule

bind sd_host_top sd_host_sva u_sva (
	.sys_clk  (sys_clk),
	.rst_n    (rst_n),
	.cmd_oe   (cmd_oe),
	.rd_valid (rd_valid),
	.rd_busy  (rd_busy),
	.rd_done  (rd_done),
	.rx_state (u_resp_rx.state)
);

// ==== sd_host_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD host top: controller, clock divider and
// command, response and data paths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_host_top (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic        rd_req,
	input  logic [31:0] rd_block,
	input  logic        cmd_in,
	input  logic [3:0]  dat_in,
	output logic        sd_clk,
	output logic        cmd_oe,
	output logic        cmd_out,
	output logic        card_ready,
	output logic        init_error,
	output logic        rd_busy,
	output logic        rd_valid,
	output logic [7:0]  rd_data,
	output logic        rd_done,
	output logic        rd_error
);
	import sd_proto_pkg::*;

	logic       fast_mode;
	logic       rise_tick;
	logic       fall_tick;
	logic       cmd_start;
	cmd_frame_t cmd_frame;
	logic       cmd_sent;
	logic       resp_start;
	logic       resp_long;
	logic       resp_done;
	logic       resp_timeout;
	resp_t      resp_data;
	logic       data_start;
	logic       data_done;
	logic       data_timeout;

	sd_clk_gen u_clk_gen (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.fast_mode (fast_mode),
		.sd_clk    (sd_clk),
		.rise_tick (rise_tick),
		.fall_tick (fall_tick)
	);

	sd_cmd_tx u_cmd_tx (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.fall_tick (fall_tick),
		.cmd_start (cmd_start),
		.cmd_frame (cmd_frame),
		.cmd_oe    (cmd_oe),
		.cmd_out   (cmd_out),
		.cmd_sent  (cmd_sent)
	);

	sd_resp_rx u_resp_rx (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.rise_tick    (rise_tick),
		.resp_start   (resp_start),
		.resp_long    (resp_long),
		.cmd_sent     (cmd_sent),
		.cmd_in       (cmd_in),
		.resp_done    (resp_done),
		.resp_timeout (resp_timeout),
		.resp_data    (resp_data)
	);

	sd_data_rx u_data_rx (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.rise_tick    (rise_tick),
		.data_start   (data_start),
		.cmd_sent     (cmd_sent),
		.dat_in       (dat_in),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.data_done    (data_done),
		.data_timeout (data_timeout)
	);

	sd_card_ctrl u_ctrl (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.rise_tick    (rise_tick),
		.rd_req       (rd_req),
		.rd_block     (rd_block),
		.cmd_sent     (cmd_sent),
		.resp_done    (resp_done),
		.resp_timeout (resp_timeout),
		.resp_data    (resp_data),
		.data_done    (data_done),
		.data_timeout (data_timeout),
		.fast_mode    (fast_mode),
		.cmd_start    (cmd_start),
		.cmd_frame    (cmd_frame),
		.resp_start   (resp_start),
		.resp_long    (resp_long),
		.data_start   (data_start),
		.card_ready   (card_ready),
		.init_error   (init_error),
		.rd_busy      (rd_busy),
		.rd_done      (rd_done),
		.rd_error     (rd_error)
	);

endmodule

// ==== sd_proto_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD bus protocol constants: command indices,
// command arguments, response bit positions,
// frame and response types, card type
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sd_proto_pkg;

	localparam logic [5:0] CMD_GO_IDLE       = 6'd0;
	localparam logic [5:0] CMD_ALL_SEND_CID  = 6'd2;
	localparam logic [5:0] CMD_SEND_RCA      = 6'd3;
	localparam logic [5:0] ACMD_BUS_WIDTH    = 6'd6;
	localparam logic [5:0] CMD_SELECT        = 6'd7;
	localparam logic [5:0] CMD_SEND_IF_COND  = 6'd8;
	localparam logic [5:0] CMD_READ_SINGLE   = 6'd17;
	localparam logic [5:0] ACMD_SEND_OP_COND = 6'd41;
	localparam logic [5:0] CMD_APP           = 6'd55;

	localparam logic [31:0] IF_COND_ARG     = 32'h0000_01aa; // 2.7-3.6 v, pattern aa
	localparam logic [31:0] OCR_HCS_ARG     = 32'h40ff_8000; // hcs set, full voltage window
	localparam logic [31:0] OCR_STD_ARG     = 32'h00ff_8000;
	localparam logic [31:0] BUS_WIDTH_4_ARG = 32'h0000_0002;

	// positions inside the 48-bit response, start bit at 47
	localparam int RESP_IDX_LSB = 40;
	localparam int RESP_ARG_LSB = 8;
	localparam int OCR_BUSY_BIT = 39; // ocr[31], high once power-up is done
	localparam int OCR_CCS_BIT  = 38; // ocr[30]
	localparam int APP_CMD_BIT  = 13; // card status bit 5

	typedef logic [37:0] cmd_frame_t; // index and argument
	typedef logic [47:0] resp_t;
	typedef enum logic [1:0] {CARD_NONE, CARD_V1_SDSC, CARD_V2_SDSC, CARD_SDHC} card_type_e;

endpackage

// ==== sd_resp_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command response receiver: start bit hunt with
// timeout, short or long shift, ncc wait
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module sd_resp_rx (
	input  logic                sys_clk,
	input  logic                rst_n,
	input  logic                rise_tick,
	input  logic                resp_start,
	input  logic                resp_long,
	input  logic                cmd_sent,
	input  logic                cmd_in,
	output logic                resp_done,
	output logic                resp_timeout,
	output sd_proto_pkg::resp_t resp_data
);
	import sd_timing_pkg::*;

	localparam int BW = $clog2(LONG_BITS);
	localparam int TW = $clog2(RESP_TIMEOUT);

	typedef enum logic [2:0] {R_IDLE, R_WAIT, R_HUNT, R_SHIFT, R_NCC} rx_state_e;

	rx_state_e     state;
	logic          long_q;
	logic [BW-1:0] bit_cnt;
	logic [BW-1:0] last_bit;
	logic [TW-1:0] tick_cnt;

	assign last_bit = long_q ? BW'(LONG_BITS - 1) : BW'(SHORT_BITS - 1);

	// only the last 48 bits stay, enough for every field checked
	always_ff @(posedge sys_clk)
	begin
		if (rise_tick && ((state == R_HUNT && !cmd_in) || state == R_SHIFT))
			resp_data <= {resp_data[46:0], cmd_in};
	end

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= R_IDLE;
			long_q       <= 1'b0;
			bit_cnt      <= '0;
			tick_cnt     <= '0;
			resp_done    <= 1'b0;
			resp_timeout <= 1'b0;
		end
		else
		begin
			resp_done    <= 1'b0;
			resp_timeout <= 1'b0;
			case (state)
				R_IDLE:
					if (resp_start)
					begin
						long_q <= resp_long;
						state  <= R_WAIT;
					end
				R_WAIT:
					if (cmd_sent) // command line released
					begin
						tick_cnt <= '0;
						state    <= R_HUNT;
					end
				R_HUNT:
					if (rise_tick)
					begin
						if (!cmd_in)
						begin
							bit_cnt <= BW'(1); // start bit counted
							state   <= R_SHIFT;
						end
						else if (tick_cnt == TW'(RESP_TIMEOUT - 1))
						begin
							resp_done    <= 1'b1;
							resp_timeout <= 1'b1;
							state        <= R_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				R_SHIFT:
					if (rise_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == last_bit)
						begin
							tick_cnt <= '0;
							state    <= R_NCC;
						end
					end
				R_NCC:
					if (rise_tick)
					begin
						if (tick_cnt == TW'(NCC_TICKS - 1))
						begin
							resp_done <= 1'b1;
							state     <= R_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				default:
					state <= R_IDLE;
			endcase
		end
	end

endmodule

// ==== sd_timing_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD host timing: clock dividers, wait counts,
// timeouts, block and response sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sd_timing_pkg;

	localparam int INIT_HALF = 8; // sys_clk cycles per half sd_clk, init rate
	localparam int DATA_HALF = 2; // transfer rate

	localparam int POWERUP_TICKS   = 80;  // sd_clk periods before cmd0
	localparam int RESP_TIMEOUT    = 80;  // ticks allowed to a response start bit
	localparam int NCC_TICKS       = 8;   // idle ticks after a response
	localparam int DATA_TIMEOUT    = 400; // ticks allowed to the data start nibble
	localparam int DATA_TAIL_TICKS = 17;  // crc16 plus end nibble

	localparam int BLOCK_BYTES = 512;
	localparam int SHORT_BITS  = 48;
	localparam int LONG_BITS   = 136;

endpackage

// ==== tb_sd_host.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD host testbench: clock, reset, card model,
// init sequence checks, random block reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module tb_sd_host;
	import sd_proto_pkg::*;
	import sd_timing_pkg::*;

	localparam logic [15:0] CARD_RCA   = 16'hb37a;
	localparam int          INIT_LIMIT = 100000;
	localparam int          READ_LIMIT = 20000;
	localparam int          EDGE_LIMIT = 100;

	logic        sys_clk;
	logic        rst_n;
	logic        rd_req;
	logic [31:0] rd_block;
	logic        cmd_in;
	logic [3:0]  dat_in;
	logic        sd_clk;
	logic        cmd_oe;
	logic        cmd_out;
	logic        card_ready;
	logic        init_error;
	logic        rd_busy;
	logic        rd_valid;
	logic [7:0]  rd_data;
	logic        rd_done;
	logic        rd_error;
	logic        sdhc_mode;
	logic        withhold;
	logic [7:0]  blk_mem [0:511];
	int          cmd_cnt;
	logic [5:0]  last_idx;
	logic [31:0] last_arg;
	logic        frame_ok;
	logic [5:0]  idx_q [$];
	logic [31:0] arg_q [$];
	int          seed;
	int          hc_seq [13] = '{0, 8, 55, 41, 55, 41, 55, 41, 2, 3, 7, 55, 6};
	int          v1_seq [14] = '{0, 8, 0, 55, 41, 55, 41, 55, 41, 2, 3, 7, 55, 6};

	sd_host_top u_sd_host_top (
		.sys_clk (sys_clk), .rst_n (rst_n), .rd_req (rd_req), .rd_block (rd_block),
		.cmd_in (cmd_in), .dat_in (dat_in), .sd_clk (sd_clk), .cmd_oe (cmd_oe),
		.cmd_out (cmd_out), .card_ready (card_ready), .init_error (init_error),
		.rd_busy (rd_busy), .rd_valid (rd_valid), .rd_data (rd_data),
		.rd_done (rd_done), .rd_error (rd_error)
	);

	sd_card_model #(.CARD_RCA(CARD_RCA)) u_card (
		.sd_clk (sd_clk), .cmd_oe (cmd_oe), .cmd_out (cmd_out), .sdhc_mode (sdhc_mode),
		.withhold (withhold), .blk_mem (blk_mem), .cmd_in (cmd_in), .dat_in (dat_in),
		.cmd_cnt (cmd_cnt), .last_idx (last_idx), .last_arg (last_arg),
		.frame_ok (frame_ok)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever
			#20 sys_clk = ~sys_clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	// log every command the card decodes
	always @(cmd_cnt)
	begin
		if (cmd_cnt > 0)
		begin
			@(negedge sys_clk); // frame fields settled
			assert (frame_ok) else fail_now($sformatf(
				"command %0d has a bad start, transmit, crc7 or end bit", last_idx));
			idx_q.push_back(last_idx);
			arg_q.push_back(last_arg);
		end
	end

	task automatic apply_reset();
		@(posedge sys_clk);
		#2 rst_n = 1'b0;
		repeat (4) @(posedge sys_clk);
		#2 rst_n = 1'b1;
		idx_q.delete();
		arg_q.delete();
	endtask

	task automatic check_idle();
		@(negedge sys_clk);
		assert (!cmd_oe) else fail_now("cmd_oe high after reset");
		assert (!card_ready) else fail_now("card_ready high after reset");
		assert (!rd_busy) else fail_now("rd_busy high after reset");
		assert (!rd_valid) else fail_now("rd_valid high after reset");
		assert (!rd_done) else fail_now("rd_done high after reset");
		assert (!rd_error) else fail_now("rd_error high after reset");
		assert (!init_error) else fail_now("init_error high after reset");
	endtask

	// sys_clk cycles between two rising sd_clk edges
	task automatic check_clk_rate(input int half);
		int   cycles;
		int   rises;
		int   period;
		logic prev;
		cycles = 0;
		rises  = 0;
		period = 0;
		@(negedge sys_clk);
		prev = sd_clk;
		while (rises < 2)
		begin
			@(negedge sys_clk);
			cycles++;
			assert (cycles < EDGE_LIMIT) else fail_now("timeout waiting for sd_clk edges");
			if (rises == 1)
				period++;
			if (sd_clk && !prev)
				rises++;
			prev = sd_clk;
		end
		assert (period == 2 * half) else fail_now($sformatf(
			"mismatch sd_clk period: got %h expected %h", period, 2 * half));
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!card_ready)
		begin
			@(negedge sys_clk);
			cycles++;
			assert (!init_error) else fail_now("initialization ended in init_error");
			assert (cycles < INIT_LIMIT) else fail_now("timeout waiting for card_ready");
		end
	endtask

	task automatic check_init(input bit v1);
		int          n;
		int          exp_idx;
		logic [31:0] exp_arg;
		n = v1 ? 14 : 13;
		assert (idx_q.size() == n) else fail_now($sformatf(
			"mismatch command count: got %h expected %h", idx_q.size(), n));
		for (int i = 0; i < n; i++)
		begin
			exp_idx = v1 ? v1_seq[i] : hc_seq[i];
			assert (idx_q[i] == 6'(exp_idx)) else fail_now($sformatf(
				"mismatch command index %0d: got %h expected %h", i, idx_q[i], exp_idx));
			case (exp_idx)
				8:       exp_arg = IF_COND_ARG;
				41:      exp_arg = v1 ? OCR_STD_ARG : OCR_HCS_ARG;
				55:      exp_arg = (i == n - 2) ? {CARD_RCA, 16'h0000} : 32'h0; // after select
				7:       exp_arg = {CARD_RCA, 16'h0000};
				6:       exp_arg = 32'h0000_0002;
				default: exp_arg = 32'h0;
			endcase
			assert (arg_q[i] == exp_arg) else fail_now($sformatf(
				"mismatch argument of cmd %0d: got %h expected %h", exp_idx, arg_q[i], exp_arg));
		end
	endtask

	task automatic do_read(input bit sdhc, input bit expect_err);
		logic [31:0] blk;
		logic [31:0] exp_arg;
		int          n_bytes;
		int          n_before;
		int          cycles;
		bit          done;
		blk = $random(seed);
		for (int i = 0; i < 512; i++)
			blk_mem[i] = 8'($random(seed));
		exp_arg  = sdhc ? blk : (blk << 9); // byte address on sdsc
		n_before = idx_q.size();
		@(posedge sys_clk);
		#2;
		rd_req   = 1'b1;
		rd_block = blk;
		@(posedge sys_clk);
		#2;
		rd_req  = 1'b0;
		n_bytes = 0;
		cycles  = 0;
		done    = 1'b0;
		while (!done)
		begin
			@(negedge sys_clk);
			cycles++;
			assert (cycles < READ_LIMIT) else fail_now("timeout waiting for rd_done");
			if (rd_valid)
			begin
				assert (n_bytes < 512) else fail_now("more than 512 bytes in one block");
				assert (rd_data == blk_mem[n_bytes]) else fail_now($sformatf(
					"mismatch rd_data byte %0d: got %h expected %h",
					n_bytes, rd_data, blk_mem[n_bytes]));
				n_bytes++;
			end
			if (rd_done)
				done = 1'b1;
		end
		assert (rd_error == expect_err) else fail_now($sformatf(
			"mismatch rd_error: got %h expected %h", rd_error, expect_err));
		assert (!rd_busy) else fail_now("rd_busy still high at rd_done");
		if (!expect_err)
		begin
			assert (n_bytes == 512) else fail_now($sformatf(
				"mismatch byte count: got %h expected %h", n_bytes, 512));
		end
		else
		begin
			assert (n_bytes == 0) else fail_now($sformatf(
				"mismatch byte count: got %h expected %h", n_bytes, 0));
		end
		assert (idx_q.size() == n_before + 1) else fail_now($sformatf(
			"mismatch commands per read: got %h expected %h", idx_q.size() - n_before, 1));
		assert (idx_q[$] == 6'd17) else fail_now($sformatf(
			"mismatch read command index: got %h expected %h", idx_q[$], 17));
		assert (arg_q[$] == exp_arg) else fail_now($sformatf(
			"mismatch cmd17 argument: got %h expected %h", arg_q[$], exp_arg));
	endtask

	initial
	begin
		seed      = 32'h7cd4;
		rst_n     = 1'b0;
		rd_req    = 1'b0;
		rd_block  = '0;
		sdhc_mode = 1'b1;
		withhold  = 1'b0;
		foreach (blk_mem[i])
			blk_mem[i] = 8'h00;
		apply_reset();
		check_idle();
		check_clk_rate(INIT_HALF);
		wait_ready();
		check_clk_rate(DATA_HALF);
		check_init(1'b0);
		repeat (3)
			do_read(1'b1, 1'b0);
		withhold = 1'b1; // card sends r1 only
		do_read(1'b1, 1'b1);
		withhold = 1'b0;
		do_read(1'b1, 1'b0);
		sdhc_mode = 1'b0;
		apply_reset();
		check_idle();
		check_clk_rate(INIT_HALF);
		wait_ready();
		check_clk_rate(DATA_HALF);
		check_init(1'b1);
		repeat (2)
			do_read(1'b0, 1'b0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
sd_proto_pkg.sv
sd_timing_pkg.sv
sd_clk_gen.sv
sd_cmd_tx.sv
sd_resp_rx.sv
sd_data_rx.sv
sd_card_ctrl.sv
sd_host_top.sv
sd_host_sva.sv
sd_card_model.sv
tb_sd_host.sv
